// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lcd_subsys_tb -f verilog.f

# keep running past assertion errors so the testbench prints its summary
./obj_dir/Vlcd_subsys_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "run_sim: passed"
else
	echo "run_sim: failed"
	exit 1
fi

// ==== tb/lcd_subsys_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_subsys_asserts (
	input logic               clk,
	input logic               rst_n,
	input lcd_pkg::lcd_state_t state,
	input logic               e,
	input logic               pop,
	input logic               valid
);
	import lcd_pkg::*;

	int fail_cnt = 0;   // read by the testbench at the end

	a_e_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(e) |-> (state == st_init || state == st_pulse))
		else begin
			$error("enable rose outside init or word pulse");
			fail_cnt++;
		end

	a_pop_idle: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> (state == st_idle))
		else begin
			$error("fifo pop outside idle");
			fail_cnt++;
		end

	a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_idle && !valid) |=> (state == st_idle))
		else begin
			$error("engine left idle with an empty fifo");
			fail_cnt++;
		end

endmodule

bind lcd_ctrl lcd_subsys_asserts u_asserts (
	.clk   (clk),
	.rst_n (rst_n),
	.state (state),
	.e     (e),
	.pop   (pop),
	.valid (valid)
);

`default_nettype wire

// ==== tb/lcd_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_subsys_tb;
	import lcd_pkg::*;
	import axil_pkg::*;

	localparam int clk_per_us = 2;
	localparam int fifo_depth = 4;
	localparam int n_steps    = 28;
	localparam int watch_ns   = (t_power_up + 440 + n_steps * t_word * 2) * clk_per_us * 10 * 2;

	typedef enum logic [2:0] {k_idle, k_read, k_write, k_rand, k_wait_init, k_drain} step_kind_t;

	typedef struct packed {
		step_kind_t          kind;
		logic [addr_w-1:0]   addr;
		logic [data_w-1:0]   data;   // write value, expected read value or cycle count
		axil_resp_t          resp;
	} step_t;

	logic                clk;
	logic                rst_n;
	logic [addr_w-1:0]   awaddr;
	logic                awvalid;
	logic                awready;
	logic [data_w-1:0]   wdata;
	logic [data_w/8-1:0] wstrb;
	logic                wvalid;
	logic                wready;
	axil_resp_t          bresp;
	logic                bvalid;
	logic                bready;
	logic [addr_w-1:0]   araddr;
	logic                arvalid;
	logic                arready;
	logic [data_w-1:0]   rdata;
	axil_resp_t          rresp;
	logic                rvalid;
	logic                rready;
	logic                e;
	logic                rs;
	logic                rw;
	logic [7:0]          lcd_data;

	step_t       steps [n_steps];
	int          errors;
	logic [31:0] rng;
	logic        chained;      // previous word still queued behind the engine
	logic        start_seen;
	logic [9:0]  exp_word_q [$];
	int          exp_high_q [$];
	int          exp_gap_q [$];   // 0 means spacing not checked
	logic [9:0]  got_word_q [$];
	int          got_high_q [$];
	int          got_rise_q [$];
	int          cycle_cnt;
	int          rise_cycle;
	logic        e_prev;

	lcd_subsys_top #(
		.clk_per_us (clk_per_us),
		.fifo_depth (fifo_depth)
	) DUT (
		.clk (clk), .rst_n (rst_n),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.e (e), .rs (rs), .rw (rw), .lcd_data (lcd_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic axil_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
			output axil_resp_t resp);
		logic aw_go;
		logic w_go;
		@(negedge clk);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = 4'hf;
		wvalid  = 1'b1;
		bready  = 1'b1;
		while (awvalid || wvalid) begin
			aw_go = awvalid && awready;   // handshake on the coming edge
			w_go  = wvalid && wready;
			@(negedge clk);
			if (aw_go)
				awvalid = 1'b0;
			if (w_go)
				wvalid = 1'b0;
		end
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
			output axil_resp_t resp);
		logic ar_go;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b1;
		while (arvalid) begin
			ar_go = arvalid && arready;
			@(negedge clk);
			if (ar_go)
				arvalid = 1'b0;
		end
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// queue the strobes a successful write should produce
	task automatic expect_write(input logic [addr_w-1:0] addr, input logic [31:0] word);
		if (addr == reg_cmd) begin
			exp_word_q.push_back(word[9:0]);
			exp_high_q.push_back(t_e_high * clk_per_us);
			exp_gap_q.push_back(chained ? t_word * clk_per_us : 0);
			chained = 1'b1;
		end else if (addr == reg_ctrl && word[8] && !start_seen) begin
			start_seen = 1'b1;
			chained    = 1'b0;
			check_value("e strobes before start", 32'(got_word_q.size()), 32'd0);
			exp_word_q.push_back({2'b00, 4'b0011, word[6], word[5], 2'b00});
			exp_word_q.push_back({2'b00, 5'b00001, word[4], word[3], word[2]});
			exp_word_q.push_back(10'h001);
			exp_word_q.push_back({2'b00, 6'b000001, word[1], word[0]});
			repeat (4)
				exp_high_q.push_back(t_step * clk_per_us);
			exp_gap_q.push_back(0);
			exp_gap_q.push_back((t_step + t_gap) * clk_per_us);
			exp_gap_q.push_back((t_step + t_gap) * clk_per_us);
			exp_gap_q.push_back((t_step + t_clear_gap) * clk_per_us);
		end
	endtask

	task automatic run_step(input step_t s);
		logic [31:0] word;
		logic [31:0] rd_v;
		axil_resp_t  resp_v;
		case (s.kind)
			k_idle: begin
				repeat (s.data)
					@(negedge clk);
				chained = 1'b0;
			end
			k_read: begin
				axil_read(s.addr, rd_v, resp_v);
				check_value("rresp", 32'(resp_v), 32'(s.resp));
				if (s.resp == resp_okay)
					check_value("rdata", rd_v, s.data);
			end
			k_write, k_rand: begin
				word = s.data;
				if (s.kind == k_rand) begin
					rng  = next_random(rng);
					word = {22'd0, rng[9:0]};
				end
				axil_write(s.addr, word, resp_v);
				check_value("bresp", 32'(resp_v), 32'(s.resp));
				if (s.resp == resp_okay)
					expect_write(s.addr, word);
			end
			k_wait_init: begin
				rd_v = '0;
				while (!rd_v[1])
					axil_read(reg_status, rd_v, resp_v);
				chained = 1'b0;
			end
			default: begin   // drain: engine idle and fifo empty
				rd_v = 32'h1;
				while (rd_v[0] || rd_v[11:4] != 8'd0)
					axil_read(reg_status, rd_v, resp_v);
				chained = 1'b0;
			end
		endcase
	endtask

	task automatic load_steps();
		steps[0]  = '{k_idle, 4'h0, 32'd200, resp_okay};
		steps[1]  = '{k_read, reg_status, 32'h001, resp_okay};   // busy, not initialized
		steps[2]  = '{k_write, 4'hc, 32'h0, resp_slverr};
		steps[3]  = '{k_read, 4'hc, 32'h0, resp_slverr};
		steps[4]  = '{k_write, reg_ctrl, 32'h15e, resp_okay};   // 2 lines, cursor blink
		steps[5]  = '{k_wait_init, 4'h0, 32'h0, resp_okay};
		steps[6]  = '{k_read, reg_status, 32'h002, resp_okay};
		steps[7]  = '{k_write, reg_ctrl, 32'h103, resp_okay};   // second start is ignored
		steps[8]  = '{k_write, reg_cmd, 32'h248, resp_okay};
		steps[9]  = '{k_write, reg_cmd, 32'h269, resp_okay};
		steps[10] = '{k_write, reg_cmd, 32'h0c0, resp_okay};
		steps[11] = '{k_drain, 4'h0, 32'h0, resp_okay};
		for (int i = 12; i < 17; i++)
			steps[i] = '{k_rand, reg_cmd, 32'h0, resp_okay};
		steps[17] = '{k_drain, 4'h0, 32'h0, resp_okay};
		for (int i = 18; i < 23; i++)
			steps[i] = '{k_write, reg_cmd, 32'(10'h22d + i), resp_okay};
		steps[23] = '{k_write, reg_cmd, 32'h2ee, resp_slverr};   // fifo full
		steps[24] = '{k_write, reg_cmd, 32'h2ef, resp_slverr};
		steps[25] = '{k_read, reg_status, 32'h047, resp_okay};
		steps[26] = '{k_drain, 4'h0, 32'h0, resp_okay};
		steps[27] = '{k_read, reg_status, 32'h002, resp_okay};
	endtask

	task automatic compare_strobes();
		check_value("e strobe count", 32'(got_word_q.size()), 32'(exp_word_q.size()));
		for (int i = 0; i < got_word_q.size() && i < exp_word_q.size(); i++) begin
			check_value("rs/rw/lcd_data", 32'(got_word_q[i]), 32'(exp_word_q[i]));
			if (i < got_high_q.size())
				check_value("e high cycles", 32'(got_high_q[i]), 32'(exp_high_q[i]));
			if (i > 0 && exp_gap_q[i] != 0)
				check_value("e rise spacing", 32'(got_rise_q[i] - got_rise_q[i-1]),
					32'(exp_gap_q[i]));
		end
	endtask

	// lcd bus monitor, sampled away from the active edge
	always @(negedge clk) begin
		if (!rst_n) begin
			e_prev    = 1'b0;
			cycle_cnt = 0;
		end else begin
			cycle_cnt++;
			if (e && !e_prev) begin
				got_word_q.push_back({rs, rw, lcd_data});
				got_rise_q.push_back(cycle_cnt);
				rise_cycle = cycle_cnt;
			end else if (!e && e_prev) begin
				got_high_q.push_back(cycle_cnt - rise_cycle);
			end
			e_prev = e;
		end
	end

	initial begin
		#(watch_ns);
		$display("timeout: run did not complete within %0d ns", watch_ns);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int afails;
		rst_n      = 1'b0;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		errors     = 0;
		rng        = 32'h0385e6f9;
		chained    = 1'b0;
		start_seen = 1'b0;
		rise_cycle = 0;
		load_steps();
		repeat (3)
			@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_steps; i++)
			run_step(steps[i]);
		compare_strobes();
		afails = DUT.u_ctrl.u_asserts.fail_cnt;
		$display("check errors: %0d, assertion failures: %0d", errors, afails);
		if (errors == 0 && afails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/lcd_pkg.sv
verilog/axil_pkg.sv
verilog/lcd_cmd_fifo.sv
verilog/lcd_ctrl.sv
verilog/lcd_axil_regs.sv
verilog/lcd_subsys_top.sv
tb/lcd_subsys_asserts.sv
tb/lcd_subsys_tb.sv

// ==== verilog/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axil_resp_t;

	localparam int addr_w = 4;
	localparam int data_w = 32;

	// register map
	localparam logic [addr_w-1:0] reg_ctrl   = 4'h0;   // cfg[6:0], start[8]
	localparam logic [addr_w-1:0] reg_cmd    = 4'h4;   // one bus word, write only
	localparam logic [addr_w-1:0] reg_status = 4'h8;   // read only

endpackage

`default_nettype wire

// ==== verilog/lcd_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_axil_regs #(
	parameter int fifo_depth = 8
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [axil_pkg::addr_w-1:0]         awaddr,
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [axil_pkg::data_w-1:0]         wdata,
	input  logic [axil_pkg::data_w/8-1:0]       wstrb,
	input  logic                                wvalid,
	output logic                                wready,
	output axil_pkg::axil_resp_t                bresp,
	output logic                                bvalid,
	input  logic                                bready,
	input  logic [axil_pkg::addr_w-1:0]         araddr,
	input  logic                                arvalid,
	output logic                                arready,
	output logic [axil_pkg::data_w-1:0]         rdata,
	output axil_pkg::axil_resp_t                rresp,
	output logic                                rvalid,
	input  logic                                rready,
	output logic                                push,
	output logic [lcd_pkg::word_w-1:0]          push_word,
	input  logic                                full,
	input  logic [7:0]                          level,
	output logic                                start,
	output logic [lcd_pkg::cfg_w-1:0]           cfg,
	input  logic                                busy,
	input  logic                                init_done
);
	import axil_pkg::*;
	import lcd_pkg::*;

	logic                  aw_held;   // address taken, waiting for data
	logic                  w_held;
	logic [addr_w-1:0]     awaddr_q;
	logic [data_w-1:0]     wdata_q;
	logic [data_w/8-1:0]   wstrb_q;
	logic                  aw_hs;
	logic                  w_hs;
	logic                  ar_hs;
	logic                  wr_fire;
	logic [addr_w-1:0]     wr_addr;
	logic [data_w-1:0]     wr_data;
	logic [data_w/8-1:0]   wr_strb;
	logic                  ctrl_wr;
	logic                  cmd_wr;
	logic                  cmd_ok;
	logic                  started;
	axil_resp_t            wr_resp;
	logic [data_w-1:0]     status_word;

	assign aw_hs   = awvalid && awready;
	assign w_hs    = wvalid && wready;
	assign ar_hs   = arvalid && arready;
	assign wr_fire = (aw_held || aw_hs) && (w_held || w_hs) && !bvalid;

	always_comb begin
		wr_addr = aw_held ? awaddr_q : awaddr;   // same cycle or held
		wr_data = w_held ? wdata_q : wdata;
		wr_strb = w_held ? wstrb_q : wstrb;
		ctrl_wr = wr_fire && (wr_addr == reg_ctrl);
		cmd_wr  = wr_fire && (wr_addr == reg_cmd);
		cmd_ok  = (wr_strb[1:0] == 2'b11) && !full;   // partial word is rejected
		push      = cmd_wr && cmd_ok;
		push_word = wr_data[word_w-1:0];
		if (wr_addr == reg_ctrl)
			wr_resp = resp_okay;
		else if ((wr_addr == reg_cmd) && cmd_ok)
			wr_resp = resp_okay;
		else
			wr_resp = resp_slverr;   // full fifo, status or unmapped
	end

	always_comb begin
		status_word        = '0;
		status_word[0]     = busy;
		status_word[1]     = init_done;
		status_word[2]     = full;
		status_word[11:4]  = level;
	end

	// write channel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b0;
			start   <= 1'b0;
			started <= 1'b0;
			cfg     <= '0;
		end else begin
			start <= 1'b0;
			if (awready)
				awready <= 1'b0;   // handshake done this cycle
			else
				awready <= awvalid && !aw_held && !bvalid;
			if (wready)
				wready <= 1'b0;
			else
				wready <= wvalid && !w_held && !bvalid;
			aw_held <= (aw_held || aw_hs) && !wr_fire;
			w_held  <= (w_held || w_hs) && !wr_fire;
			if (bvalid && bready)
				bvalid <= 1'b0;
			else if (wr_fire)
				bvalid <= 1'b1;
			if (ctrl_wr) begin
				if (wr_strb[0])
					cfg <= wr_data[cfg_w-1:0];
				if (wr_strb[1] && wr_data[8] && !started) begin
					start   <= 1'b1;   // one pulse per reset
					started <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			awaddr_q <= awaddr;
		if (w_hs) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
		if (wr_fire)
			bresp <= wr_resp;
	end

	// read channel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			if (arready)
				arready <= 1'b0;
			else
				arready <= arvalid && !rvalid;
			if (ar_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			case (araddr)
				reg_ctrl: begin
					rdata <= data_w'({started, 1'b0, cfg});
					rresp <= resp_okay;
				end
				reg_status: begin
					rdata <= status_word;
					rresp <= resp_okay;
				end
				default: begin
					rdata <= '0;   // cmd is write only
					rresp <= resp_slverr;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lcd_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_cmd_fifo #(
	parameter int fifo_depth = 8
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        push,
	input  logic [lcd_pkg::word_w-1:0]  push_word,
	input  logic                        pop,
	output logic                        valid,
	output logic [lcd_pkg::word_w-1:0]  head_word,
	output logic                        full,
	output logic [7:0]                  level
);
	import lcd_pkg::*;

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam logic [ptr_w-1:0] ptr_last = ptr_w'(fifo_depth - 1);

	logic [word_w-1:0] mem [fifo_depth];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic              do_push;
	logic              do_pop;

	assign valid     = (level != 8'd0);
	assign full      = (level == 8'(fifo_depth));
	assign head_word = mem[rd_ptr];   // first word fall through
	assign do_pop    = pop && valid;
	assign do_push   = push && (!full || do_pop);   // pop frees a slot when full

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= 8'd0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   level <= level + 8'd1;
				2'b01:   level <= level - 8'd1;
				default: level <= level;   // none, or both
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_word;
	end

endmodule

`default_nettype wire

// ==== verilog/lcd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl #(
	parameter int clk_per_us = 15
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        start,
	input  logic [lcd_pkg::cfg_w-1:0]   cfg,
	input  logic                        valid,
	input  logic [lcd_pkg::word_w-1:0]  head_word,
	output logic                        pop,
	output logic                        busy,
	output logic                        init_done,
	output logic                        e,
	output logic                        rs,
	output logic                        rw,
	output logic [7:0]                  lcd_data
);
	import lcd_pkg::*;

	localparam int pwr_cyc = t_power_up * clk_per_us;
	localparam int cnt_w   = $clog2(pwr_cyc + 1);   // power-up is the longest wait

	localparam logic [cnt_w-1:0] pwr_last   = cnt_w'(pwr_cyc - 1);
	localparam logic [cnt_w-1:0] step_cyc   = cnt_w'(t_step * clk_per_us);
	// end of each init phase, counted from the first function set cycle
	localparam logic [cnt_w-1:0] fs_end     = step_cyc;
	localparam logic [cnt_w-1:0] fs_gap_end = fs_end + cnt_w'(t_gap * clk_per_us);
	localparam logic [cnt_w-1:0] dc_end     = fs_gap_end + step_cyc;
	localparam logic [cnt_w-1:0] dc_gap_end = dc_end + cnt_w'(t_gap * clk_per_us);
	localparam logic [cnt_w-1:0] cl_end     = dc_gap_end + step_cyc;
	localparam logic [cnt_w-1:0] cl_gap_end = cl_end + cnt_w'(t_clear_gap * clk_per_us);
	localparam logic [cnt_w-1:0] em_end     = cl_gap_end + step_cyc;
	localparam logic [cnt_w-1:0] init_last  = em_end + cnt_w'(t_entry_gap * clk_per_us - 1);
	// per word enable window
	localparam logic [cnt_w-1:0] lead_cyc   = cnt_w'(t_e_lead * clk_per_us);
	localparam logic [cnt_w-1:0] high_end   = cnt_w'((t_e_lead + t_e_high) * clk_per_us);
	localparam logic [cnt_w-1:0] word_last  = cnt_w'(t_word * clk_per_us - 2);

	lcd_state_t        state;
	logic [cnt_w-1:0]  cnt;
	logic [cnt_w-1:0]  cnt_inc;
	logic [cnt_w-1:0]  seq_pos;    // init position of the next cycle
	logic              pwr_run;    // power-up wait running
	logic [cfg_w-1:0]  cfg_q;
	logic              init_e;
	logic [7:0]        init_byte;
	logic              pulse_e;

	assign pop  = (state == st_idle) && valid;
	assign busy = (state != st_idle);

	always_comb begin
		cnt_inc   = cnt + 1'b1;
		seq_pos   = (state == st_init) ? cnt_inc : '0;
		init_e    = 1'b0;
		init_byte = 8'h00;
		if (seq_pos < fs_end) begin
			init_e    = 1'b1;   // function set
			init_byte = {4'b0011, cfg_q[cfg_lines], cfg_q[cfg_font], 2'b00};
		end else if (seq_pos < fs_gap_end) begin
			init_e = 1'b0;
		end else if (seq_pos < dc_end) begin
			init_e    = 1'b1;   // display on/off control
			init_byte = {5'b00001, cfg_q[cfg_disp], cfg_q[cfg_cursor], cfg_q[cfg_blink]};
		end else if (seq_pos < dc_gap_end) begin
			init_e = 1'b0;
		end else if (seq_pos < cl_end) begin
			init_e    = 1'b1;
			init_byte = cmd_clear;
		end else if (seq_pos < cl_gap_end) begin
			init_e = 1'b0;
		end else if (seq_pos < em_end) begin
			init_e    = 1'b1;   // entry mode set
			init_byte = {6'b000001, cfg_q[cfg_inc_dec], cfg_q[cfg_shift]};
		end
		pulse_e = (cnt_inc >= lead_cyc) && (cnt_inc < high_end);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= st_power_up;
			cnt       <= '0;
			pwr_run   <= 1'b0;
			init_done <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= 8'h00;
		end else begin
			case (state)
				st_power_up: begin
					if (!pwr_run) begin
						pwr_run <= start;
						cnt     <= '0;
					end else if (cnt == pwr_last) begin
						state    <= st_init;
						cnt      <= '0;
						e        <= init_e;   // first function set cycle
						lcd_data <= init_byte;
					end else begin
						cnt <= cnt_inc;
					end
				end
				st_init: begin
					if (cnt == init_last) begin
						state     <= st_idle;
						cnt       <= '0;
						init_done <= 1'b1;
						e         <= 1'b0;
						lcd_data  <= 8'h00;
					end else begin
						cnt      <= cnt_inc;
						e        <= init_e;
						lcd_data <= init_byte;
					end
				end
				st_idle: begin
					cnt <= '0;
					e   <= 1'b0;
					if (valid) begin
						state    <= st_pulse;   // word popped this cycle
						rs       <= head_word[word_rs_bit];
						rw       <= head_word[word_rw_bit];
						lcd_data <= head_word[7:0];
					end else begin
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
					end
				end
				st_pulse: begin
					if (cnt == word_last) begin
						state <= st_idle;
						cnt   <= '0;
						e     <= 1'b0;
					end else begin
						cnt <= cnt_inc;
						e   <= pulse_e;
					end
				end
				default: state <= st_power_up;
			endcase
		end
	end

	// config sampled when start arrives
	always_ff @(posedge clk) begin
		if ((state == st_power_up) && !pwr_run && start)
			cfg_q <= cfg;
	end

endmodule

`default_nettype wire

// ==== verilog/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	// timing engine states
	typedef enum logic [1:0] {
		st_power_up,
		st_init,
		st_idle,
		st_pulse
	} lcd_state_t;

	// bus word is {rs, rw, data[7:0]}
	localparam int word_w      = 10;
	localparam int word_rs_bit = 9;
	localparam int word_rw_bit = 8;

	// config is {lines, font, display on, cursor, blink, inc_dec, shift}
	localparam int cfg_w       = 7;
	localparam int cfg_lines   = 6;
	localparam int cfg_font    = 5;
	localparam int cfg_disp    = 4;
	localparam int cfg_cursor  = 3;
	localparam int cfg_blink   = 2;
	localparam int cfg_inc_dec = 1;
	localparam int cfg_shift   = 0;

	localparam logic [7:0] cmd_clear = 8'h01;   // display clear

	// all times in microseconds
	localparam int t_power_up  = 500;
	localparam int t_step      = 10;   // e high per init command
	localparam int t_gap       = 50;
	localparam int t_clear_gap = 200;
	localparam int t_entry_gap = 100;
	localparam int t_word      = 50;   // pop to pop for queued words
	localparam int t_e_lead    = 1;
	localparam int t_e_high    = 13;

endpackage

`default_nettype wire

// ==== verilog/lcd_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_subsys_top #(
	parameter int clk_per_us = 15,
	parameter int fifo_depth = 8
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [axil_pkg::addr_w-1:0]    awaddr,
	input  logic                           awvalid,
	output logic                           awready,
	input  logic [axil_pkg::data_w-1:0]    wdata,
	input  logic [axil_pkg::data_w/8-1:0]  wstrb,
	input  logic                           wvalid,
	output logic                           wready,
	output axil_pkg::axil_resp_t           bresp,
	output logic                           bvalid,
	input  logic                           bready,
	input  logic [axil_pkg::addr_w-1:0]    araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output logic [axil_pkg::data_w-1:0]    rdata,
	output axil_pkg::axil_resp_t           rresp,
	output logic                           rvalid,
	input  logic                           rready,
	output logic                           e,
	output logic                           rs,
	output logic                           rw,
	output logic [7:0]                     lcd_data
);
	import lcd_pkg::*;

	logic              push;
	logic [word_w-1:0] push_word;
	logic              full;
	logic [7:0]        level;
	logic              valid;
	logic [word_w-1:0] head_word;
	logic              pop;
	logic              start;
	logic [cfg_w-1:0]  cfg;
	logic              busy;
	logic              init_done;

	lcd_axil_regs #(
		.fifo_depth (fifo_depth)
	) u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.push      (push),
		.push_word (push_word),
		.full      (full),
		.level     (level),
		.start     (start),
		.cfg       (cfg),
		.busy      (busy),
		.init_done (init_done)
	);

	lcd_cmd_fifo #(
		.fifo_depth (fifo_depth)
	) u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_word (push_word),
		.pop       (pop),
		.valid     (valid),
		.head_word (head_word),
		.full      (full),
		.level     (level)
	);

	lcd_ctrl #(
		.clk_per_us (clk_per_us)
	) u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.cfg       (cfg),
		.valid     (valid),
		.head_word (head_word),
		.pop       (pop),
		.busy      (busy),
		.init_done (init_done),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

endmodule

`default_nettype wire
